//--- source/lc3b_types.sv
`default_nettype none

package lc3b_types;

	// Datapath widths
	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [3:0] lc3b_opcode;
	typedef logic [4:0] lc3b_imm5;

	// Station slot index that doubles as the result tag
	typedef logic [2:0] rs_tag_t;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_AND,
		ALU_NOT
	} alu_op_t;

	// Supported opcodes
	localparam lc3b_opcode OP_ADD = 4'b0001;
	localparam lc3b_opcode OP_AND = 4'b0101;
	localparam lc3b_opcode OP_NOT = 4'b1001;

	// imm5 to word
	function automatic lc3b_word sext5(input lc3b_imm5 imm);
		sext5 = {{11{imm[4]}}, imm};
	endfunction

endpackage

`default_nettype wire

//--- source/issue_control.sv
`timescale 1ns/1ps
`default_nettype none

module issue_control #(
	parameter int N_STATIONS = 4
) (
	input logic clk,
	input logic arst_n,
	input lc3b_types::lc3b_word instr,
	input logic instr_is_new,
	input logic [N_STATIONS-1:0] slot_busy,
	input logic cdb_valid,
	input lc3b_types::rs_tag_t cdb_tag,
	input lc3b_types::lc3b_word cdb_data,
	input lc3b_types::lc3b_word rd_a_value,
	input logic rd_a_busy,
	input lc3b_types::rs_tag_t rd_a_tag,
	input lc3b_types::lc3b_word rd_b_value,
	input logic rd_b_busy,
	input lc3b_types::rs_tag_t rd_b_tag,
	output logic instr_ready,
	output lc3b_types::lc3b_reg rd_a_sel,
	output lc3b_types::lc3b_reg rd_b_sel,
	output logic set_busy,
	output lc3b_types::lc3b_reg set_reg,
	output lc3b_types::rs_tag_t set_tag,
	output logic issue_valid,
	output lc3b_types::rs_tag_t issue_slot,
	output lc3b_types::alu_op_t issue_op,
	output lc3b_types::lc3b_word issue_vj,
	output lc3b_types::lc3b_word issue_vk,
	output lc3b_types::rs_tag_t issue_qj,
	output lc3b_types::rs_tag_t issue_qk,
	output logic issue_rj,
	output logic issue_rk
);
	import lc3b_types::*;

	lc3b_opcode opcode;
	logic imm_mode;
	logic supported;
	rs_tag_t free_slot;
	logic [N_STATIONS-1:0] free_onehot;
	logic [N_STATIONS-1:0] issue_onehot;
	logic ready_q;

	// Instruction fields
	assign opcode = instr[15:12];
	assign imm_mode = instr[5];
	assign rd_a_sel = instr[8:6];
	assign rd_b_sel = instr[2:0];

	always_comb begin
		supported = 1'b1;
		issue_op = ALU_ADD;
		case (opcode)
			OP_ADD: issue_op = ALU_ADD;
			OP_AND: issue_op = ALU_AND;
			OP_NOT: issue_op = ALU_NOT;
			default: supported = 1'b0;
		endcase
	end

	// Lowest free slot wins
	always_comb begin
		free_slot = '0;
		free_onehot = '0;
		for (int i = N_STATIONS - 1; i >= 0; i--) begin
			if (!slot_busy[i]) begin
				free_slot = rs_tag_t'(i);
				free_onehot = '0;
				free_onehot[i] = 1'b1;
			end
		end
	end

	// Unsupported opcodes are accepted but never reach a station
	assign issue_valid = instr_is_new && ready_q && supported;
	assign issue_slot = free_slot;
	assign issue_onehot = issue_valid ? free_onehot : '0;

	// Destination gets the station tag at the same edge
	assign set_busy = issue_valid;
	assign set_reg = instr[11:9];
	assign set_tag = free_slot;

	// Source 1 takes the register or CDB value or waits on the tag
	always_comb begin
		issue_vj = rd_a_value;
		issue_qj = rd_a_tag;
		issue_rj = 1'b1;
		if (rd_a_busy) begin
			if (cdb_valid && cdb_tag == rd_a_tag)
				issue_vj = cdb_data;
			else
				issue_rj = 1'b0;
		end
	end

	// Source 2 or the immediate
	always_comb begin
		issue_vk = rd_b_value;
		issue_qk = rd_b_tag;
		issue_rk = 1'b1;
		if (issue_op == ALU_NOT) begin
			issue_vk = '0;
			issue_qk = '0;
		end else if (imm_mode) begin
			issue_vk = sext5(instr[4:0]);
			issue_qk = '0;
		end else if (rd_b_busy) begin
			if (cdb_valid && cdb_tag == rd_b_tag)
				issue_vk = cdb_data;
			else
				issue_rk = 1'b0;
		end
	end

	// Registered ready level that sees a slot freed by dispatch one cycle late
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ready_q <= 1'b1;
		else
			ready_q <= |(~slot_busy & ~issue_onehot);
	end

	assign instr_ready = ready_q;

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input logic clk,
	input logic arst_n,
	input lc3b_types::lc3b_reg rd_a_sel,
	input lc3b_types::lc3b_reg rd_b_sel,
	input logic set_busy,
	input lc3b_types::lc3b_reg set_reg,
	input lc3b_types::rs_tag_t set_tag,
	input logic cdb_valid,
	input lc3b_types::rs_tag_t cdb_tag,
	input lc3b_types::lc3b_word cdb_data,
	input lc3b_types::lc3b_reg dbg_sel,
	output lc3b_types::lc3b_word rd_a_value,
	output logic rd_a_busy,
	output lc3b_types::rs_tag_t rd_a_tag,
	output lc3b_types::lc3b_word rd_b_value,
	output logic rd_b_busy,
	output lc3b_types::rs_tag_t rd_b_tag,
	output lc3b_types::lc3b_word dbg_value,
	output logic dbg_busy
);
	import lc3b_types::*;

	lc3b_word reg_value [8];
	logic [7:0] reg_busy;
	rs_tag_t reg_tag [8];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reg_busy <= '0;
			for (int i = 0; i < 8; i++) begin
				reg_value[i] <= '0;
				reg_tag[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 8; i++) begin
				// New producer takes over even if the old one retires now
				if (set_busy && set_reg == lc3b_reg'(i)) begin
					reg_busy[i] <= 1'b1;
					reg_tag[i] <= set_tag;
				end else if (cdb_valid && reg_busy[i] && reg_tag[i] == cdb_tag) begin
					reg_value[i] <= cdb_data;
					reg_busy[i] <= 1'b0;
				end
			end
		end
	end

	// Read ports
	assign rd_a_value = reg_value[rd_a_sel];
	assign rd_a_busy = reg_busy[rd_a_sel];
	assign rd_a_tag = reg_tag[rd_a_sel];
	assign rd_b_value = reg_value[rd_b_sel];
	assign rd_b_busy = reg_busy[rd_b_sel];
	assign rd_b_tag = reg_tag[rd_b_sel];

	assign dbg_value = reg_value[dbg_sel];
	assign dbg_busy = reg_busy[dbg_sel];

endmodule

`default_nettype wire

//--- source/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
	parameter int N_STATIONS = 4
) (
	input logic clk,
	input logic arst_n,
	input logic issue_valid,
	input lc3b_types::rs_tag_t issue_slot,
	input lc3b_types::alu_op_t issue_op,
	input lc3b_types::lc3b_word issue_vj,
	input lc3b_types::lc3b_word issue_vk,
	input lc3b_types::rs_tag_t issue_qj,
	input lc3b_types::rs_tag_t issue_qk,
	input logic issue_rj,
	input logic issue_rk,
	input logic cdb_valid,
	input lc3b_types::rs_tag_t cdb_tag,
	input lc3b_types::lc3b_word cdb_data,
	input logic dispatch_valid,
	input lc3b_types::rs_tag_t dispatch_slot,
	output logic [N_STATIONS-1:0] slot_busy,
	output logic [N_STATIONS-1:0] slot_ready,
	output lc3b_types::alu_op_t [N_STATIONS-1:0] slot_op,
	output lc3b_types::lc3b_word [N_STATIONS-1:0] slot_vj,
	output lc3b_types::lc3b_word [N_STATIONS-1:0] slot_vk
);
	import lc3b_types::*;

	rs_tag_t qj [N_STATIONS];
	rs_tag_t qk [N_STATIONS];
	logic [N_STATIONS-1:0] rj;
	logic [N_STATIONS-1:0] rk;

	// Occupancy and operand-ready flags
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			slot_busy <= '0;
			rj <= '0;
			rk <= '0;
		end else begin
			for (int i = 0; i < N_STATIONS; i++) begin
				if (issue_valid && issue_slot == rs_tag_t'(i)) begin
					slot_busy[i] <= 1'b1;
					rj[i] <= issue_rj;
					rk[i] <= issue_rk;
				end else begin
					if (dispatch_valid && dispatch_slot == rs_tag_t'(i))
						slot_busy[i] <= 1'b0;
					if (cdb_valid && slot_busy[i] && !rj[i] && qj[i] == cdb_tag)
						rj[i] <= 1'b1;
					if (cdb_valid && slot_busy[i] && !rk[i] && qk[i] == cdb_tag)
						rk[i] <= 1'b1;
				end
			end
		end
	end

	// Entry payload filled at issue or by CDB snoop
	always_ff @(posedge clk) begin
		for (int i = 0; i < N_STATIONS; i++) begin
			if (issue_valid && issue_slot == rs_tag_t'(i)) begin
				slot_op[i] <= issue_op;
				slot_vj[i] <= issue_vj;
				slot_vk[i] <= issue_vk;
				qj[i] <= issue_qj;
				qk[i] <= issue_qk;
			end else begin
				if (cdb_valid && !rj[i] && qj[i] == cdb_tag)
					slot_vj[i] <= cdb_data;
				if (cdb_valid && !rk[i] && qk[i] == cdb_tag)
					slot_vk[i] <= cdb_data;
			end
		end
	end

	assign slot_ready = slot_busy & rj & rk;

endmodule

`default_nettype wire

//--- source/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
	parameter int N_STATIONS = 4
) (
	input logic clk,
	input logic arst_n,
	input logic [N_STATIONS-1:0] slot_ready,
	input lc3b_types::alu_op_t [N_STATIONS-1:0] slot_op,
	input lc3b_types::lc3b_word [N_STATIONS-1:0] slot_vj,
	input lc3b_types::lc3b_word [N_STATIONS-1:0] slot_vk,
	output logic dispatch_valid,
	output lc3b_types::rs_tag_t dispatch_slot,
	output logic cdb_valid,
	output lc3b_types::rs_tag_t cdb_tag,
	output lc3b_types::lc3b_word cdb_data
);
	import lc3b_types::*;

	alu_op_t sel_op;
	lc3b_word sel_a;
	lc3b_word sel_b;
	lc3b_word result;

	// Lowest ready slot goes first
	always_comb begin
		dispatch_valid = 1'b0;
		dispatch_slot = '0;
		sel_op = ALU_ADD;
		sel_a = '0;
		sel_b = '0;
		for (int i = N_STATIONS - 1; i >= 0; i--) begin
			if (slot_ready[i]) begin
				dispatch_valid = 1'b1;
				dispatch_slot = rs_tag_t'(i);
				sel_op = slot_op[i];
				sel_a = slot_vj[i];
				sel_b = slot_vk[i];
			end
		end
	end

	always_comb begin
		case (sel_op)
			ALU_AND: result = sel_a & sel_b;
			ALU_NOT: result = ~sel_a;
			default: result = sel_a + sel_b;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			cdb_valid <= 1'b0;
		else
			cdb_valid <= dispatch_valid;
	end

	// Tag and data only mean something while cdb_valid is high
	always_ff @(posedge clk) begin
		if (dispatch_valid) begin
			cdb_tag <= dispatch_slot;
			cdb_data <= result;
		end
	end

endmodule

`default_nettype wire

//--- source/tomasulo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core #(
	parameter int N_STATIONS = 4
) (
	input logic clk,
	input logic arst_n,
	input lc3b_types::lc3b_word instr,
	input logic instr_is_new,
	input lc3b_types::lc3b_reg dbg_sel,
	output logic instr_ready,
	output logic cdb_valid,
	output lc3b_types::rs_tag_t cdb_tag,
	output lc3b_types::lc3b_word cdb_data,
	output lc3b_types::lc3b_word dbg_value,
	output logic dbg_busy
);
	import lc3b_types::*;

	// Register file read ports
	lc3b_reg rd_a_sel;
	lc3b_reg rd_b_sel;
	lc3b_word rd_a_value;
	lc3b_word rd_b_value;
	logic rd_a_busy;
	logic rd_b_busy;
	rs_tag_t rd_a_tag;
	rs_tag_t rd_b_tag;

	// Destination marking
	logic set_busy;
	lc3b_reg set_reg;
	rs_tag_t set_tag;

	// Issue to station
	logic issue_valid;
	rs_tag_t issue_slot;
	alu_op_t issue_op;
	lc3b_word issue_vj;
	lc3b_word issue_vk;
	rs_tag_t issue_qj;
	rs_tag_t issue_qk;
	logic issue_rj;
	logic issue_rk;

	// Station and ALU
	logic [N_STATIONS-1:0] slot_busy;
	logic [N_STATIONS-1:0] slot_ready;
	alu_op_t [N_STATIONS-1:0] slot_op;
	lc3b_word [N_STATIONS-1:0] slot_vj;
	lc3b_word [N_STATIONS-1:0] slot_vk;
	logic dispatch_valid;
	rs_tag_t dispatch_slot;

	issue_control #(
		.N_STATIONS(N_STATIONS)
	) u_issue_control (
		.clk(clk),
		.arst_n(arst_n),
		.instr(instr),
		.instr_is_new(instr_is_new),
		.slot_busy(slot_busy),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.rd_a_value(rd_a_value),
		.rd_a_busy(rd_a_busy),
		.rd_a_tag(rd_a_tag),
		.rd_b_value(rd_b_value),
		.rd_b_busy(rd_b_busy),
		.rd_b_tag(rd_b_tag),
		.instr_ready(instr_ready),
		.rd_a_sel(rd_a_sel),
		.rd_b_sel(rd_b_sel),
		.set_busy(set_busy),
		.set_reg(set_reg),
		.set_tag(set_tag),
		.issue_valid(issue_valid),
		.issue_slot(issue_slot),
		.issue_op(issue_op),
		.issue_vj(issue_vj),
		.issue_vk(issue_vk),
		.issue_qj(issue_qj),
		.issue_qk(issue_qk),
		.issue_rj(issue_rj),
		.issue_rk(issue_rk)
	);

	register_file u_register_file (
		.clk(clk),
		.arst_n(arst_n),
		.rd_a_sel(rd_a_sel),
		.rd_b_sel(rd_b_sel),
		.set_busy(set_busy),
		.set_reg(set_reg),
		.set_tag(set_tag),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.dbg_sel(dbg_sel),
		.rd_a_value(rd_a_value),
		.rd_a_busy(rd_a_busy),
		.rd_a_tag(rd_a_tag),
		.rd_b_value(rd_b_value),
		.rd_b_busy(rd_b_busy),
		.rd_b_tag(rd_b_tag),
		.dbg_value(dbg_value),
		.dbg_busy(dbg_busy)
	);

	reservation_station #(
		.N_STATIONS(N_STATIONS)
	) u_reservation_station (
		.clk(clk),
		.arst_n(arst_n),
		.issue_valid(issue_valid),
		.issue_slot(issue_slot),
		.issue_op(issue_op),
		.issue_vj(issue_vj),
		.issue_vk(issue_vk),
		.issue_qj(issue_qj),
		.issue_qk(issue_qk),
		.issue_rj(issue_rj),
		.issue_rk(issue_rk),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.dispatch_valid(dispatch_valid),
		.dispatch_slot(dispatch_slot),
		.slot_busy(slot_busy),
		.slot_ready(slot_ready),
		.slot_op(slot_op),
		.slot_vj(slot_vj),
		.slot_vk(slot_vk)
	);

	alu_unit #(
		.N_STATIONS(N_STATIONS)
	) u_alu_unit (
		.clk(clk),
		.arst_n(arst_n),
		.slot_ready(slot_ready),
		.slot_op(slot_op),
		.slot_vj(slot_vj),
		.slot_vk(slot_vk),
		.dispatch_valid(dispatch_valid),
		.dispatch_slot(dispatch_slot),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data)
	);

endmodule

`default_nettype wire

//--- bench/tomasulo_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core_tb;

	localparam int WAIT_LIMIT = 200;
	localparam int DRAIN_LIMIT = 60;
	localparam logic [3:0] ADD_OPC = 4'b0001;
	localparam logic [3:0] AND_OPC = 4'b0101;
	localparam logic [3:0] NOT_OPC = 4'b1001;

	logic clk;
	logic arst_n;
	logic [15:0] instr;
	logic instr_is_new;
	logic [2:0] dbg_sel;
	logic instr_ready;
	logic cdb_valid;
	logic [2:0] cdb_tag;
	logic [15:0] cdb_data;
	logic [15:0] dbg_value;
	logic dbg_busy;

	// Architectural registers in program order
	logic [15:0] model_regs [8];
	int issued_total = 0;
	int cdb_count = 0;
	int check_count = 0;
	int error_count = 0;

	tomasulo_core #(
		.N_STATIONS(4)
	) UUT (
		.clk(clk),
		.arst_n(arst_n),
		.instr(instr),
		.instr_is_new(instr_is_new),
		.dbg_sel(dbg_sel),
		.instr_ready(instr_ready),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.dbg_value(dbg_value),
		.dbg_busy(dbg_busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// One broadcast per cycle with cdb_valid high
	always @(negedge clk) begin
		if (arst_n && cdb_valid)
			cdb_count++;
	end

	function automatic logic [15:0] encode(input logic [3:0] opcode, input logic [2:0] dr,
			input logic [2:0] sr1, input logic imm_mode, input logic [4:0] low);
		encode = {opcode, dr, sr1, imm_mode, low};
	endfunction

	function automatic logic is_supported(input logic [3:0] opcode);
		is_supported = (opcode == ADD_OPC) || (opcode == AND_OPC) || (opcode == NOT_OPC);
	endfunction

	// Sequential LC-3b semantics
	function automatic logic [15:0] model_result(input logic [15:0] word);
		logic [15:0] a;
		logic [15:0] b;
		a = model_regs[word[8:6]];
		if (word[5])
			b = {{11{word[4]}}, word[4:0]};
		else
			b = model_regs[word[2:0]];
		case (word[15:12])
			AND_OPC: model_result = a & b;
			NOT_OPC: model_result = ~a;
			default: model_result = a + b;
		endcase
	endfunction

	task automatic abort_on_timeout(input string what);
		$display("Timeout: gave up waiting for %s", what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t %s: got 0x%h, expected 0x%h", $time, name, actual, expected);
		end
	endtask

	// Starts and ends 1 ns after a rising edge
	task automatic issue_instr(input logic [15:0] word);
		int waited;
		waited = 0;
		while (!instr_ready) begin
			if (waited == WAIT_LIMIT)
				abort_on_timeout("instr_ready");
			@(posedge clk);
			#1;
			waited++;
		end
		instr = word;
		instr_is_new = 1'b1;
		@(posedge clk);
		#1;
		instr_is_new = 1'b0;
		if (is_supported(word[15:12])) begin
			model_regs[word[11:9]] = model_result(word);
			issued_total++;
		end
	endtask

	task automatic read_debug(input logic [2:0] sel, output logic [15:0] value,
			output logic busy);
		dbg_sel = sel;
		@(negedge clk);
		value = dbg_value;
		busy = dbg_busy;
		@(posedge clk);
		#1;
	endtask

	// Every issued result broadcast and no register waiting on a tag
	task automatic drain;
		int polls;
		logic idle;
		logic [15:0] value;
		logic busy;
		polls = 0;
		idle = 1'b0;
		while (!idle) begin
			if (polls == DRAIN_LIMIT)
				abort_on_timeout("the register file to drain");
			idle = (cdb_count >= issued_total);
			for (int r = 0; r < 8; r++) begin
				read_debug(3'(r), value, busy);
				if (busy)
					idle = 1'b0;
			end
			polls++;
		end
	endtask

	task automatic check_regs;
		logic [15:0] value;
		logic busy;
		for (int r = 0; r < 8; r++) begin
			read_debug(3'(r), value, busy);
			check_value($sformatf("r%0d value", r), value, model_regs[r]);
			check_value($sformatf("r%0d busy", r), 16'(busy), 16'h0000);
		end
	endtask

	task automatic check_reset_state;
		$display("Reset state");
		check_value("instr_ready", 16'(instr_ready), 16'h0001);
		check_value("cdb_valid", 16'(cdb_valid), 16'h0000);
		check_regs();
	endtask

	// Immediate chain then register operands that wait on tags
	task automatic raw_chain;
		$display("RAW chain");
		issue_instr(encode(ADD_OPC, 3'd1, 3'd0, 1'b1, 5'd5));
		issue_instr(encode(ADD_OPC, 3'd2, 3'd1, 1'b1, 5'd3));
		issue_instr(encode(ADD_OPC, 3'd3, 3'd2, 1'b1, 5'h1f));
		issue_instr(encode(ADD_OPC, 3'd4, 3'd1, 1'b0, 5'd2));
		issue_instr(encode(ADD_OPC, 3'd5, 3'd4, 1'b0, 5'd3));
		issue_instr(encode(ADD_OPC, 3'd6, 3'd5, 1'b0, 5'd5));
		issue_instr(encode(ADD_OPC, 3'd7, 3'd6, 1'b0, 5'd4));
		drain();
		check_regs();
	endtask

	task automatic logic_ops;
		$display("AND and NOT");
		issue_instr(encode(NOT_OPC, 3'd0, 3'd1, 1'b1, 5'h1f));
		issue_instr(encode(AND_OPC, 3'd2, 3'd0, 1'b0, 5'd6));
		issue_instr(encode(AND_OPC, 3'd3, 3'd0, 1'b1, 5'h18));
		issue_instr(encode(NOT_OPC, 3'd4, 3'd4, 1'b1, 5'h1f));
		issue_instr(encode(AND_OPC, 3'd5, 3'd7, 1'b1, 5'd12));
		// Unsupported opcode is swallowed without touching r1
		issue_instr(encode(4'b1101, 3'd1, 3'd5, 1'b1, 5'h0b));
		issue_instr(encode(ADD_OPC, 3'd6, 3'd3, 1'b1, 5'h10));
		drain();
		check_regs();
	endtask

	// Last writer of r2 must win
	task automatic waw_overwrite;
		$display("WAW on r2");
		issue_instr(encode(ADD_OPC, 3'd2, 3'd5, 1'b0, 5'd6));
		issue_instr(encode(AND_OPC, 3'd2, 3'd0, 1'b1, 5'd0));
		issue_instr(encode(ADD_OPC, 3'd2, 3'd7, 1'b1, 5'd9));
		issue_instr(encode(NOT_OPC, 3'd2, 3'd3, 1'b1, 5'h1f));
		issue_instr(encode(ADD_OPC, 3'd2, 3'd2, 1'b1, 5'd2));
		drain();
		check_regs();
	endtask

	// Lone instruction on an idle core takes slot 0 and the fastest path
	task automatic cdb_fast_path;
		int cycles;
		$display("CDB fast path");
		issue_instr(encode(ADD_OPC, 3'd1, 3'd7, 1'b1, 5'h13));
		cycles = 1;
		@(negedge clk);
		while (!cdb_valid) begin
			if (cycles == WAIT_LIMIT)
				abort_on_timeout("cdb_valid");
			@(negedge clk);
			cycles++;
		end
		check_value("cdb_valid latency", 16'(cycles), 16'd2);
		check_value("cdb_tag", 16'(cdb_tag), 16'h0000);
		check_value("cdb_data", cdb_data, model_regs[1]);
		@(posedge clk);
		#1;
		drain();
		check_regs();
	endtask

	task automatic random_stream;
		logic [31:0] pick;
		logic [31:0] fields;
		logic [3:0] opc;
		logic [15:0] word;
		int cdb_start;
		$display("Random stream");
		cdb_start = cdb_count;
		for (int n = 0; n < 24; n++) begin
			pick = $urandom;
			fields = $urandom;
			case (pick % 3)
				0: opc = ADD_OPC;
				1: opc = AND_OPC;
				default: opc = NOT_OPC;
			endcase
			if (opc == NOT_OPC)
				word = encode(opc, fields[2:0], fields[5:3], 1'b1, 5'h1f);
			else if (fields[6])
				word = encode(opc, fields[2:0], fields[5:3], 1'b1, fields[11:7]);
			else
				word = encode(opc, fields[2:0], fields[5:3], 1'b0, {2'b00, fields[9:7]});
			issue_instr(word);
		end
		drain();
		check_regs();
		check_value("cdb_valid pulses", 16'(cdb_count - cdb_start), 16'd24);
	endtask

	initial begin
		void'($urandom(23089));
		arst_n = 1'b0;
		instr = '0;
		instr_is_new = 1'b0;
		dbg_sel = '0;
		for (int r = 0; r < 8; r++)
			model_regs[r] = '0;
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;
		check_reset_state();
		raw_chain();
		logic_ops();
		waw_overwrite();
		cdb_fast_path();
		random_stream();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
source/lc3b_types.sv
source/issue_control.sv
source/register_file.sv
source/reservation_station.sv
source/alu_unit.sv
source/tomasulo_core.sv
bench/tomasulo_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tomasulo_core_tb -Mdir obj_dir -o sim
./obj_dir/sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished without failures"
